// File: bench/soc_patterns.txt
// op addr data sel expected; op 1 write, 2 read, 3 burst of four, 4 irq, 5 err, 6 mtime
// RAM reads check the shadow copy; irq addr 0 timer, 1 sw; mtime data is the gap in cycles
1 80000004 11223344 3 00000000
2 80000004 00000000 f 00000000
1 80000008 aabbccdd c 00000000
2 80000008 00000000 f 00000000
1 8000000c 55667788 6 00000000
2 8000000c 00000000 f 00000000
2 80000000 00000000 f 00000000
3 80000000 00000000 f 00000000
3 80000010 00000000 f 00000000
2 80000014 00000000 f 00000000
5 10000014 cafef00d f 00000000
2 80000014 00000000 f 00000000
4 00000001 00000000 0 00000000
1 30000000 00000001 1 00000000
4 00000001 00000000 0 00000001
2 30000000 00000000 f 00000001
1 30000000 00000000 1 00000000
4 00000001 00000000 0 00000000
1 30004000 00000000 f 00000000
1 30004004 00000000 f 00000000
4 00000000 00000000 0 00000001
1 30004004 ffffffff f 00000000
4 00000000 00000000 0 00000000
6 3000bff8 00000004 f 00000000

// File: list.f
src/soc_pkg.sv
src/wb_decoder.sv
src/line_ram.sv
src/wb_ram_slave.sv
src/clint_slave.sv
src/soc_fabric_top.sv
bench/soc_fabric_checker.sv
bench/soc_fabric_tb.sv

// File: bench/soc_fabric_tb.sv
// ==============================
// Testbench for the fabric top, run from the project root
// Patterns come from bench/soc_patterns.txt
// RAM reads compare with a shadow copy of fill and pattern writes
// ==============================
`timescale 1ns/1ps

module soc_fabric_tb;
  import soc_pkg::*;

  localparam int unsigned RAM_DEPTH_WORDS = 1024;
  localparam int unsigned RAM_LATENCY     = 4;
  localparam int unsigned PAT_MAX         = 64;
  localparam int unsigned FILL_WORDS      = 8;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;

  logic        clk_i;
  logic        rst_ni;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        timer_irq;
  logic        sw_irq;
  logic [31:0] pat_mem [PAT_MAX*5];
  wb_data_t    shadow [RAM_DEPTH_WORDS];
  logic [31:0] lfsr_q;
  logic        test_ok;
  int unsigned n_pat;
  int unsigned n_fail;

  soc_fabric_top #(
    .RAM_DEPTH_WORDS(RAM_DEPTH_WORDS),
    .RAM_LATENCY    (RAM_LATENCY)
  ) u_soc_fabric_top (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_req_i   (wb_req),
    .wb_rsp_o   (wb_rsp),
    .timer_irq_o(timer_irq),
    .sw_irq_o   (sw_irq)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  // ==============================
  // Helpers
  // ==============================

  // One Galois step, feedback from bit 0
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per data bit
  task automatic next_rand(output wb_data_t w);
    for (int i = 0; i < 32; i++) begin
      w[i]   = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Byte lanes from sel replace the old word
  function automatic wb_data_t sel_merge(wb_data_t old_w, wb_data_t new_w, logic [3:0] sel);
    wb_data_t mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic is_ram(logic [31:0] a);
    return a[31:28] == ram_base_c[31:28];
  endfunction

  function automatic int unsigned word_idx(logic [31:0] a);
    return a[2 +: $clog2(RAM_DEPTH_WORDS)];
  endfunction

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_data(string name, wb_data_t exp, wb_data_t act);
    if (act !== exp) begin
      test_ok = 1'b0;
      $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_irq(string name, logic exp, logic act);
    if (act !== exp) begin
      test_ok = 1'b0;
      $display("FAILED at %0d ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  // Only ack and err matter here
  task automatic check_err(string name, wb_rsp_t exp, wb_rsp_t act);
    if ({act.ack, act.err} !== {exp.ack, exp.err}) begin
      test_ok = 1'b0;
      $display("FAILED at %0d ns: %s ack/err expected %b/%b, got %b/%b",
               $time, name, exp.ack, exp.err, act.ack, act.err);
    end
  endtask

  task automatic no_response(logic [31:0] adr);
    test_ok = 1'b0;
    $display("At %0d ns no ack or err arrived for address %h", $time, adr);
  endtask

  // ==============================
  // Bus driver
  // ==============================

  // Samples mid-cycle until ack or err, bounded by the RAM latency
  task automatic wait_rsp(output wb_rsp_t rsp, output logic got);
    int unsigned n;
    got = 1'b0;
    n   = 0;
    rsp = '0;
    while (!got && n < RAM_LATENCY + 4) begin
      @(negedge clk_i);
      rsp = wb_rsp;
      got = rsp.ack | rsp.err;
      n++;
    end
  endtask

  // Classic cycle, stb dropped on the edge that takes the answer
  // Mapped targets answer with ack, unmapped ones with err
  task automatic single_access(input logic we, input logic [31:0] adr, input wb_data_t dat,
                               input logic [3:0] sel, input logic exp_err,
                               output wb_rsp_t rsp);
    wb_req_t r;
    wb_rsp_t rsp_exp;
    logic    got;
    r     = '0;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    r.we  = we;
    r.adr = adr;
    r.dat = dat;
    r.sel = sel;
    r.cti = cti_classic_c;
    @(posedge clk_i);
    wb_req <= r;
    wait_rsp(rsp, got);
    if (got) begin
      rsp_exp     = '0;
      rsp_exp.ack = ~exp_err;
      rsp_exp.err = exp_err;
      check_err("wb_rsp_o", rsp_exp, rsp);
    end else begin
      no_response(adr);
    end
    @(posedge clk_i);
    r.cyc = 1'b0;
    r.stb = 1'b0;
    wb_req <= r;
  endtask

  // Four incrementing beats from a line start, last one end-of-burst
  task automatic burst_read(input logic [31:0] base);
    wb_req_t r;
    wb_rsp_t rsp;
    wb_rsp_t rsp_exp;
    logic    got;
    r           = '0;
    r.cyc       = 1'b1;
    r.stb       = 1'b1;
    r.sel       = 4'hf;
    got         = 1'b1;
    rsp_exp     = '0;
    rsp_exp.ack = 1'b1;
    @(posedge clk_i);
    for (int b = 0; b < words_per_line_c && got; b++) begin
      r.adr = base + 32'(4 * b);
      r.cti = (b == words_per_line_c - 1) ? cti_eob_c : cti_incr_c;
      wb_req <= r;
      wait_rsp(rsp, got);
      if (got) begin
        check_err($sformatf("wb_rsp_o beat %0d", b), rsp_exp, rsp);
        check_data($sformatf("wb_rsp_o.dat beat %0d", b), shadow[word_idx(r.adr)], rsp.dat);
      end else begin
        no_response(r.adr);
      end
      // Next beat in the cycle after the ack
      @(posedge clk_i);
    end
    r.cyc = 1'b0;
    r.stb = 1'b0;
    wb_req <= r;
  endtask

  task automatic report(int unsigned num, logic [31:0] op, logic [31:0] adr);
    if (!test_ok) begin
      n_fail++;
    end
    $display("test %0d op %0d addr %h %s", num, op, adr, test_ok ? "ok" : "failed");
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    wb_rsp_t     rsp;
    wb_data_t    w1;
    wb_data_t    w2;
    logic [31:0] op;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] exp;
    logic [3:0]  sel;
    int unsigned limit;
    int unsigned asrt_fails;
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    wb_req = '0;
    lfsr_q = 32'd98433;
    n_fail = 0;
    n_pat  = 0;
    $readmemh("bench/soc_patterns.txt", pat_mem);
    while (n_pat < PAT_MAX && pat_mem[n_pat*5] inside {[1:6]}) begin
      n_pat++;
    end

    // Watchdog from the number of accesses
    limit = (n_pat + FILL_WORDS) * (RAM_LATENCY + 8) + 4;
    fork
      begin
        repeat (limit) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles", limit);
        $display("Finished with errors");
        $finish;
      end
    join_none

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Random fill of the first lines
    test_ok = 1'b1;
    for (int i = 0; i < FILL_WORDS; i++) begin
      next_rand(w1);
      shadow[i] = w1;
      single_access(1'b1, ram_base_c + 32'(4 * i), w1, 4'hf, 1'b0, rsp);
    end
    report(0, 0, ram_base_c);

    for (int t = 0; t < n_pat; t++) begin
      op      = pat_mem[t*5];
      adr     = pat_mem[t*5+1];
      dat     = pat_mem[t*5+2];
      sel     = pat_mem[t*5+3][3:0];
      exp     = pat_mem[t*5+4];
      test_ok = 1'b1;
      case (op)
        1: begin
          single_access(1'b1, adr, dat, sel, 1'b0, rsp);
          if (is_ram(adr)) begin
            shadow[word_idx(adr)] = sel_merge(shadow[word_idx(adr)], dat, sel);
          end
        end
        2: begin
          single_access(1'b0, adr, '0, sel, 1'b0, rsp);
          if (is_ram(adr)) begin
            exp = shadow[word_idx(adr)];
          end
          check_data("wb_rsp_o.dat", exp, rsp.dat);
        end
        3: burst_read(adr);
        4: begin
          @(negedge clk_i);
          if (adr[0]) begin
            check_irq("sw_irq_o", exp[0], sw_irq);
          end else begin
            check_irq("timer_irq_o", exp[0], timer_irq);
          end
        end
        5: single_access(1'b1, adr, dat, sel, 1'b1, rsp);
        6: begin
          single_access(1'b0, adr, '0, sel, 1'b0, rsp);
          w1 = rsp.dat;
          repeat (dat) @(posedge clk_i);
          single_access(1'b0, adr, '0, sel, 1'b0, rsp);
          w2 = rsp.dat;
          if (w2 <= w1) begin
            test_ok = 1'b0;
            $display("FAILED at %0d ns: mtime second read %h, first read %h", $time, w2, w1);
          end
        end
        default: ;
      endcase
      report(t + 1, op, adr);
    end

    asrt_fails = u_soc_fabric_top.u_soc_fabric_checker.fail_cnt;
    $display("tests %0d, failed %0d, assertion failures %0d", n_pat + 1, n_fail, asrt_fails);
    if (n_fail == 0 && asrt_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: bench/soc_fabric_checker.sv
// ==============================
// Bus response and reset checks
// Bound into soc_fabric_top, counts its own failures
// ==============================
`timescale 1ns/1ps

module soc_fabric_checker (
  input logic             clk_i,
  input logic             rst_ni,
  input soc_pkg::wb_req_t req_i,
  input soc_pkg::wb_rsp_t rsp_i,
  input logic             timer_irq_i,
  input logic             sw_irq_i
);

  // Read by the testbench at the end
  int unsigned fail_cnt = 0;

  // One answer per cycle at most
  ack_err_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rsp_i.ack && rsp_i.err))
    else begin
      fail_cnt++;
      $error("ack and err are high in the same cycle");
    end

  // Answers only to a live request
  rsp_in_cycle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_i.ack || rsp_i.err) |-> (req_i.cyc && req_i.stb))
    else begin
      fail_cnt++;
      $error("ack or err without cyc and stb");
    end

  // Quiet outputs right after reset
  reset_state_a: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!rsp_i.ack && !rsp_i.err && !timer_irq_i && !sw_irq_i))
    else begin
      fail_cnt++;
      $error("response or interrupt high after reset");
    end

endmodule

bind soc_fabric_top soc_fabric_checker u_soc_fabric_checker (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .req_i      (wb_req_i),
  .rsp_i      (wb_rsp_o),
  .timer_irq_i(timer_irq_o),
  .sw_irq_i   (sw_irq_o)
);

// File: src/soc_fabric_top.sv
// ==============================
// Memory-side fabric top
// One master, RAM and CLINT targets
// RAM_LATENCY must be at least 2
// ==============================
`timescale 1ns/1ps

module soc_fabric_top #(
  parameter int unsigned RAM_DEPTH_WORDS = 1024,
  parameter int unsigned RAM_LATENCY     = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t wb_rsp_o,
  output logic             timer_irq_o,
  output logic             sw_irq_o
);
  import soc_pkg::*;

  wb_req_t ram_req;
  wb_rsp_t ram_rsp;
  wb_req_t clint_req;
  wb_rsp_t clint_rsp;

  // ==============================
  // Address decode
  // ==============================
  wb_decoder u_wb_decoder (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .m_req_i    (wb_req_i),
    .m_rsp_o    (wb_rsp_o),
    .ram_req_o  (ram_req),
    .ram_rsp_i  (ram_rsp),
    .clint_req_o(clint_req),
    .clint_rsp_i(clint_rsp)
  );

  // Main RAM
  wb_ram_slave #(
    .RAM_DEPTH_WORDS(RAM_DEPTH_WORDS),
    .RAM_LATENCY    (RAM_LATENCY)
  ) u_wb_ram_slave (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .req_i (ram_req),
    .rsp_o (ram_rsp)
  );

  // Timer and software interrupts
  clint_slave u_clint_slave (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (clint_req),
    .rsp_o      (clint_rsp),
    .timer_irq_o(timer_irq_o),
    .sw_irq_o   (sw_irq_o)
  );

endmodule

// File: src/clint_slave.sv
// ==============================
// CLINT with mtime, mtimecmp and msip
// Ack one cycle after stb, read data registered
// Unknown offsets read zero and drop writes
// ==============================
`timescale 1ns/1ps

module clint_slave (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o,
  output logic             timer_irq_o,
  output logic             sw_irq_o
);
  import soc_pkg::*;

  localparam logic [15:0] MTIMECMP_HI = clint_mtimecmp_off_c + 16'd4;
  localparam logic [15:0] MTIME_HI    = clint_mtime_off_c + 16'd4;

  logic                     req_v;
  logic                     acc_first;
  logic                     wr_en;
  logic                     rd_en;
  logic [clint_off_w_c-1:0] reg_off;
  logic [63:0]              mtime_q;
  logic [63:0]              mtime_d;
  logic [63:0]              mtimecmp_q;
  logic                     msip_q;
  logic                     ack_q;
  wb_data_t                 rdata_d;
  wb_data_t                 rdata_q;

  // Byte-enable merge of one 32-bit half
  function automatic wb_data_t merge_bytes(wb_data_t old_val, wb_data_t new_val,
                                           logic [3:0] sel);
    wb_data_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign req_v     = req_i.cyc & req_i.stb;
  // Access acts once, in its first cycle
  assign acc_first = req_v & ~ack_q;
  assign wr_en     = acc_first & req_i.we;
  assign rd_en     = acc_first & ~req_i.we;
  assign reg_off   = {req_i.adr[clint_off_w_c-1:2], 2'b00};

  // ==============================
  // Counter
  // ==============================
  always_comb begin
    mtime_d = mtime_q + 64'd1;
    if (wr_en && (reg_off == clint_mtime_off_c)) begin
      mtime_d[31:0] = merge_bytes(mtime_q[31:0], req_i.dat, req_i.sel);
    end
    if (wr_en && (reg_off == MTIME_HI)) begin
      mtime_d[63:32] = merge_bytes(mtime_q[63:32], req_i.dat, req_i.sel);
    end
  end

  // ==============================
  // Registers
  // ==============================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      mtime_q <= mtime_d;
      ack_q   <= acc_first;
      if (wr_en) begin
        case (reg_off)
          clint_msip_off_c: begin
            if (req_i.sel[0]) begin
              msip_q <= req_i.dat[0];
            end
          end
          clint_mtimecmp_off_c: begin
            mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], req_i.dat, req_i.sel);
          end
          MTIMECMP_HI: begin
            mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], req_i.dat, req_i.sel);
          end
          default: ;
        endcase
      end
    end
  end

  // Read select
  always_comb begin
    case (reg_off)
      clint_msip_off_c:     rdata_d = {31'b0, msip_q};
      clint_mtimecmp_off_c: rdata_d = mtimecmp_q[31:0];
      MTIMECMP_HI:          rdata_d = mtimecmp_q[63:32];
      clint_mtime_off_c:    rdata_d = mtime_q[31:0];
      MTIME_HI:             rdata_d = mtime_q[63:32];
      default:              rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o.dat = rdata_q;
  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;

  // Interrupt levels
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign sw_irq_o    = msip_q;

endmodule

// File: src/wb_ram_slave.sv
// ==============================
// Word bus to line RAM adapter
// Writes ack at once, reads after the RAM latency
// Burst beats after the first come from the line buffer
// ==============================
`timescale 1ns/1ps

module wb_ram_slave #(
  parameter int unsigned RAM_DEPTH_WORDS = 1024,
  parameter int unsigned RAM_LATENCY     = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o
);
  import soc_pkg::*;

  localparam int unsigned LINE_AW = $clog2(RAM_DEPTH_WORDS / words_per_line_c);

  logic                    req_v;
  logic                    wr_req;
  logic                    rd_req;
  logic [LINE_AW-1:0]      line_addr;
  logic [word_sel_w_c-1:0] word_sel;
  logic                    keep_line;
  logic [line_w_c-1:0]     wdata_line;
  logic [line_w_c/8-1:0]   wstrb_line;
  logic                    rd_en;
  logic [line_w_c-1:0]     rdata_line;
  logic                    rvalid;
  logic                    line_ack;
  logic                    beat_ack;
  logic                    pending_q;
  logic                    burst_act_q;
  logic [word_sel_w_c-1:0] beat_cnt_q;
  logic [line_w_c-1:0]     line_buf_q;

  assign req_v     = req_i.cyc & req_i.stb;
  assign wr_req    = req_v & req_i.we;
  assign rd_req    = req_v & ~req_i.we;
  assign line_addr = req_i.adr[line_off_w_c +: LINE_AW];
  assign word_sel  = req_i.adr[2 +: word_sel_w_c];

  // Line kept for later beats unless this is a single or last beat
  assign keep_line = !(req_i.cti inside {cti_classic_c, cti_eob_c});

  // ==============================
  // Write path
  // ==============================
  always_comb begin
    wstrb_line = '0;
    // Same word in every slot, strobes pick the slot
    for (int i = 0; i < words_per_line_c; i++) begin
      wdata_line[i*32 +: 32] = req_i.dat;
    end
    if (wr_req) begin
      wstrb_line[word_sel*4 +: 4] = req_i.sel;
    end
  end

  // ==============================
  // Read path
  // ==============================

  // One line read per single access or burst start
  assign rd_en = rd_req & ~pending_q & ~burst_act_q;

  line_ram #(
    .RAM_DEPTH_WORDS(RAM_DEPTH_WORDS),
    .RAM_LATENCY    (RAM_LATENCY)
  ) u_line_ram (
    .clk_i      (clk_i),
    .line_addr_i(line_addr),
    .wdata_i    (wdata_line),
    .wstrb_i    (wstrb_line),
    .rd_en_i    (rd_en),
    .rdata_o    (rdata_line),
    .rvalid_o   (rvalid)
  );

  // Line arrival closes the first beat
  assign line_ack = pending_q & rvalid;
  // Later beats hit the buffer
  assign beat_ack = burst_act_q & rd_req;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pending_q   <= 1'b0;
      burst_act_q <= 1'b0;
      beat_cnt_q  <= '0;
    end else begin
      if (line_ack) begin
        pending_q <= 1'b0;
      end else if (rd_en) begin
        pending_q <= 1'b1;
      end
      if (line_ack) begin
        burst_act_q <= keep_line;
        beat_cnt_q  <= word_sel + 1'b1;
      end else if (beat_ack) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        // Buffer freed on the last beat
        if (req_i.cti == cti_eob_c) begin
          burst_act_q <= 1'b0;
        end
      end
    end
  end

  // Line buffer
  always_ff @(posedge clk_i) begin
    if (line_ack) begin
      line_buf_q <= rdata_line;
    end
  end

  // ==============================
  // Response
  // ==============================
  always_comb begin
    rsp_o.ack = wr_req | line_ack | beat_ack;
    rsp_o.err = 1'b0;
    if (burst_act_q) begin
      rsp_o.dat = line_buf_q[beat_cnt_q*32 +: 32];
    end else begin
      rsp_o.dat = rdata_line[word_sel*32 +: 32];
    end
  end

endmodule

// File: src/line_ram.sv
// ==============================
// Line-wide storage, byte strobe writes
// Read data is ready RAM_LATENCY cycles after rd_en_i
// line_addr_i must stay stable while a read is in flight
// ==============================
`timescale 1ns/1ps

module line_ram #(
  parameter int unsigned RAM_DEPTH_WORDS = 1024,
  parameter int unsigned RAM_LATENCY     = 4
) (
  input  logic                                                     clk_i,
  input  logic [$clog2(RAM_DEPTH_WORDS/soc_pkg::words_per_line_c)-1:0] line_addr_i,
  input  logic [soc_pkg::line_w_c-1:0]                             wdata_i,
  input  logic [soc_pkg::line_w_c/8-1:0]                           wstrb_i,
  input  logic                                                     rd_en_i,
  output logic [soc_pkg::line_w_c-1:0]                             rdata_o,
  output logic                                                     rvalid_o
);
  import soc_pkg::*;

  localparam int unsigned LINE_DEPTH = RAM_DEPTH_WORDS / words_per_line_c;

  logic [line_w_c-1:0]    mem_q [LINE_DEPTH];
  logic [RAM_LATENCY-1:0] rd_pipe_q;
  logic [line_w_c-1:0]    rdata_q;

  // Byte lanes written independently
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < line_bytes_c; b++) begin
      if (wstrb_i[b]) begin
        mem_q[line_addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  // Latency pipe, line sampled one stage before the end
  always_ff @(posedge clk_i) begin
    rd_pipe_q <= {rd_pipe_q[RAM_LATENCY-2:0], rd_en_i};
    if (rd_pipe_q[RAM_LATENCY-2]) begin
      rdata_q <= mem_q[line_addr_i];
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rd_pipe_q[RAM_LATENCY-1];

endmodule

// File: src/wb_decoder.sv
// ==============================
// One master to RAM or CLINT
// Unmapped addresses get a same-cycle err pulse
// Adds no cycles to any access
// ==============================
`timescale 1ns/1ps

module wb_decoder (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t m_req_i,
  output soc_pkg::wb_rsp_t m_rsp_o,
  output soc_pkg::wb_req_t ram_req_o,
  input  soc_pkg::wb_rsp_t ram_rsp_i,
  output soc_pkg::wb_req_t clint_req_o,
  input  soc_pkg::wb_rsp_t clint_rsp_i
);
  import soc_pkg::*;

  logic [region_w_c-1:0] region;
  logic                  ram_hit;
  logic                  clint_hit;
  logic                  miss_err;
  logic                  err_blk_q;

  // ==============================
  // Region match
  // ==============================
  assign region    = m_req_i.adr[31 -: region_w_c];
  assign ram_hit   = (region == ram_base_c[31 -: region_w_c]);
  assign clint_hit = (region == clint_base_c[31 -: region_w_c]);

  // No target, so answer directly while the request is held
  assign miss_err = m_req_i.cyc & m_req_i.stb & ~ram_hit & ~clint_hit & ~err_blk_q;

  // Blocks err in the cycle after a pulse
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      err_blk_q <= 1'b0;
    end else begin
      err_blk_q <= miss_err;
    end
  end

  // Full request to both, stb only to the hit
  always_comb begin
    ram_req_o       = m_req_i;
    ram_req_o.stb   = m_req_i.stb & ram_hit;
    clint_req_o     = m_req_i;
    clint_req_o.stb = m_req_i.stb & clint_hit;
  end

  // ==============================
  // Response return
  // ==============================
  always_comb begin
    if (ram_hit) begin
      m_rsp_o = ram_rsp_i;
    end else if (clint_hit) begin
      m_rsp_o = clint_rsp_i;
    end else begin
      m_rsp_o.dat = '0;
      m_rsp_o.ack = 1'b0;
      m_rsp_o.err = miss_err;
    end
  end

endmodule

// File: src/soc_pkg.sv
// ==============================
// Shared bus types and memory map of the fabric
// Regions decode on the top address nibble only
// Bursts assume 32-bit beats inside one 128-bit line
// ==============================

package soc_pkg;

  // ==============================
  // Bus payloads
  // ==============================

  // One bus data word
  typedef logic [31:0] wb_data_t;

  // Master request, held until ack or err
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [31:0] adr;
    wb_data_t   dat;
    logic [3:0] sel;
    logic [2:0] cti;
  } wb_req_t;

  // Slave response, no stall and no retry
  typedef struct packed {
    wb_data_t dat;
    logic     ack;
    logic     err;
  } wb_rsp_t;

  // Cycle type codes
  localparam logic [2:0] cti_classic_c = 3'b000;
  localparam logic [2:0] cti_incr_c    = 3'b010;
  localparam logic [2:0] cti_eob_c     = 3'b111;

  // ==============================
  // Line geometry
  // ==============================
  localparam int unsigned line_w_c         = 128;
  localparam int unsigned words_per_line_c = line_w_c / 32;
  localparam int unsigned line_bytes_c     = line_w_c / 8;
  // Byte offset bits inside one line
  localparam int unsigned line_off_w_c     = $clog2(line_bytes_c);
  // Word slot bits inside one line
  localparam int unsigned word_sel_w_c     = $clog2(words_per_line_c);

  // ==============================
  // Address map
  // ==============================
  localparam int unsigned region_w_c   = 4;
  localparam logic [31:0] ram_base_c   = 32'h8000_0000;
  localparam logic [31:0] clint_base_c = 32'h3000_0000;

  // CLINT register offsets, high words at +4
  localparam int unsigned clint_off_w_c        = 16;
  localparam logic [15:0] clint_msip_off_c     = 16'h0000;
  localparam logic [15:0] clint_mtimecmp_off_c = 16'h4000;
  localparam logic [15:0] clint_mtime_off_c    = 16'hBFF8;

endpackage
